//--- design/axil_mem_pkg.sv
// scratch ram subsystem shared definitions
// bus widths, response codes and the ram window size

package axil_mem_pkg;

   // external axi4-lite bus
   parameter int AXIL_ADDR_WIDTH = 16;
   parameter int AXIL_DATA_WIDTH = 32;

   // one strobe per data byte
   parameter int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

   // response encoding, as on the bus
   typedef logic [1:0] resp_t;

   // normal completion
   parameter resp_t RESP_OKAY = 2'b00;

   // no slave at this address
   parameter resp_t RESP_DECERR = 2'b11;

   // ram window, byte addressed
   // 12 bits gives 4 KiB from address 0
   parameter int RAM_ADDR_WIDTH = 12;

endpackage

//--- design/axil_ram.sv
`timescale 1ns/1ps

// axi4-lite scratch ram slave
// byte strobed writes, registered read data, one response in flight per channel
// side debug port for preload and inspection by word index

module axil_ram #(
   parameter int DATA_WIDTH = 32,
   parameter int ADDR_WIDTH = 12,
   localparam int STRB_WIDTH = DATA_WIDTH / 8,
   localparam int WORD_SHIFT = $clog2(STRB_WIDTH),
   localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - WORD_SHIFT
) (
   input  logic                       clk,
   input  logic                       rst,

   // debug port, word indexed
   input  logic [WORD_ADDR_WIDTH-1:0] debug_addr,
   output logic [DATA_WIDTH-1:0]      debug_data,
   input  logic [WORD_ADDR_WIDTH-1:0] debug_wr_addr,
   input  logic [DATA_WIDTH-1:0]      debug_wr_data,
   input  logic                       debug_wr_en,

   // write address and data
   input  logic [ADDR_WIDTH-1:0]      awaddr,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [DATA_WIDTH-1:0]      wdata,
   input  logic [STRB_WIDTH-1:0]      wstrb,
   input  logic                       wvalid,
   output logic                       wready,

   // write response
   output axil_mem_pkg::resp_t        bresp,
   output logic                       bvalid,
   input  logic                       bready,

   // read address
   input  logic [ADDR_WIDTH-1:0]      araddr,
   input  logic                       arvalid,
   output logic                       arready,

   // read data
   output logic [DATA_WIDTH-1:0]      rdata,
   output axil_mem_pkg::resp_t        rresp,
   output logic                       rvalid,
   input  logic                       rready
);
   import axil_mem_pkg::*;

   logic [DATA_WIDTH-1:0]      mem [2**WORD_ADDR_WIDTH];

   // byte address with the strobe bits dropped
   logic [WORD_ADDR_WIDTH-1:0] aw_word;
   logic [WORD_ADDR_WIDTH-1:0] ar_word;

   // awready and wready always move together
   logic                       wr_ready_q;
   logic                       bvalid_q;
   logic                       wr_start;
   logic                       wr_fire;

   logic                       arready_q;
   logic                       rvalid_q;
   logic [DATA_WIDTH-1:0]      rdata_q;
   logic                       rd_start;

   assign aw_word = awaddr[ADDR_WIDTH-1:WORD_SHIFT];
   assign ar_word = araddr[ADDR_WIDTH-1:WORD_SHIFT];

   // take a write when both halves are up and b is free
   // skip the ready cycle so one request is taken once
   assign wr_start = awvalid && wvalid && !wr_ready_q && (!bvalid_q || bready);

   // bytes land on the edge the handshake completes
   assign wr_fire = awvalid && wvalid && wr_ready_q;

   // same shape for reads, r must be free
   assign rd_start = arvalid && !arready_q && (!rvalid_q || rready);

   assign awready = wr_ready_q;
   assign wready  = wr_ready_q;
   assign bvalid  = bvalid_q;
   assign arready = arready_q;
   assign rvalid  = rvalid_q;
   assign rdata   = rdata_q;

   // no error source in here
   assign bresp = RESP_OKAY;
   assign rresp = RESP_OKAY;

   // debug read is straight off the array
   assign debug_data = mem[debug_addr];

   // write channel control
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ready_q <= 1'b0;
         bvalid_q   <= 1'b0;
      end else begin
         // ready for exactly one cycle
         wr_ready_q <= wr_start;
         // response holds until bready
         bvalid_q   <= wr_start || (bvalid_q && !bready);
      end
   end

   // array update, debug and bus share one process
   // same word in the same cycle is not defined
   always_ff @(posedge clk) begin
      if (debug_wr_en) begin
         mem[debug_wr_addr] <= debug_wr_data;
      end
      for (int i = 0; i < STRB_WIDTH; i++) begin
         if (wr_fire && wstrb[i]) begin
            mem[aw_word][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
   end

   // read channel control
   always_ff @(posedge clk) begin
      if (rst) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end else begin
         arready_q <= rd_start;
         rvalid_q  <= rd_start || (rvalid_q && !rready);
      end
   end

   // read data captured on acceptance
   // stays put while rvalid waits on rready
   always_ff @(posedge clk) begin
      if (rd_start) begin
         rdata_q <= mem[ar_word];
      end
   end

endmodule

//--- design/axil_addr_decoder.sv
`timescale 1ns/1ps

// axi4-lite address decoder in front of the scratch ram
// in-window requests pass to the ram port, others get a local decode error
// an owner flag per channel steers the pending response back

module axil_addr_decoder #(
   parameter int ADDR_WIDTH = 12
) (
   input  logic                                     clk,
   input  logic                                     rst,

   // upstream slave port, from the external master
   input  logic [axil_mem_pkg::AXIL_ADDR_WIDTH-1:0] s_awaddr,
   input  logic                                     s_awvalid,
   output logic                                     s_awready,
   input  logic [axil_mem_pkg::AXIL_DATA_WIDTH-1:0] s_wdata,
   input  logic [axil_mem_pkg::AXIL_STRB_WIDTH-1:0] s_wstrb,
   input  logic                                     s_wvalid,
   output logic                                     s_wready,
   output axil_mem_pkg::resp_t                      s_bresp,
   output logic                                     s_bvalid,
   input  logic                                     s_bready,
   input  logic [axil_mem_pkg::AXIL_ADDR_WIDTH-1:0] s_araddr,
   input  logic                                     s_arvalid,
   output logic                                     s_arready,
   output logic [axil_mem_pkg::AXIL_DATA_WIDTH-1:0] s_rdata,
   output axil_mem_pkg::resp_t                      s_rresp,
   output logic                                     s_rvalid,
   input  logic                                     s_rready,

   // downstream master port, to the ram
   output logic [ADDR_WIDTH-1:0]                    m_awaddr,
   output logic                                     m_awvalid,
   input  logic                                     m_awready,
   output logic [axil_mem_pkg::AXIL_DATA_WIDTH-1:0] m_wdata,
   output logic [axil_mem_pkg::AXIL_STRB_WIDTH-1:0] m_wstrb,
   output logic                                     m_wvalid,
   input  logic                                     m_wready,
   input  axil_mem_pkg::resp_t                      m_bresp,
   input  logic                                     m_bvalid,
   output logic                                     m_bready,
   output logic [ADDR_WIDTH-1:0]                    m_araddr,
   output logic                                     m_arvalid,
   input  logic                                     m_arready,
   input  logic [axil_mem_pkg::AXIL_DATA_WIDTH-1:0] m_rdata,
   input  axil_mem_pkg::resp_t                      m_rresp,
   input  logic                                     m_rvalid,
   output logic                                     m_rready
);
   import axil_mem_pkg::*;

   logic aw_hit;
   logic ar_hit;

   // write side
   logic wr_req;
   logic wr_free;
   logic wr_owner_loc;
   logic loc_wr_ready;
   logic loc_bvalid;
   logic loc_wr_start;

   // read side
   logic rd_free;
   logic rd_owner_loc;
   logic loc_arready;
   logic loc_rvalid;
   logic loc_rd_start;

   // hit when nothing is set above the window
   assign aw_hit = (s_awaddr >> ADDR_WIDTH) == '0;
   assign ar_hit = (s_araddr >> ADDR_WIDTH) == '0;

   assign wr_req  = s_awvalid && s_wvalid;
   assign wr_free = !s_bvalid || s_bready;
   assign rd_free = !s_rvalid || s_rready;

   // address truncated to the window, payload passes as is
   assign m_awaddr = s_awaddr[ADDR_WIDTH-1:0];
   assign m_araddr = s_araddr[ADDR_WIDTH-1:0];
   assign m_wdata  = s_wdata;
   assign m_wstrb  = s_wstrb;

   // hold hits off the ram while a decerr is still waiting
   assign m_awvalid = s_awvalid && aw_hit && !(loc_bvalid && !s_bready);
   assign m_wvalid  = s_wvalid && aw_hit && !(loc_bvalid && !s_bready);
   assign m_arvalid = s_arvalid && ar_hit && !(loc_rvalid && !s_rready);

   // local miss handling mirrors the ram timing
   assign loc_wr_start = wr_req && !aw_hit && !loc_wr_ready && wr_free;
   assign loc_rd_start = s_arvalid && !ar_hit && !loc_arready && rd_free;

   // return path steered by owner
   assign s_awready = wr_owner_loc ? loc_wr_ready : m_awready;
   assign s_wready  = wr_owner_loc ? loc_wr_ready : m_wready;
   assign s_bvalid  = wr_owner_loc ? loc_bvalid : m_bvalid;
   assign s_bresp   = wr_owner_loc ? RESP_DECERR : m_bresp;
   assign m_bready  = s_bready && !wr_owner_loc;

   assign s_arready = rd_owner_loc ? loc_arready : m_arready;
   assign s_rvalid  = rd_owner_loc ? loc_rvalid : m_rvalid;
   assign s_rresp   = rd_owner_loc ? RESP_DECERR : m_rresp;
   assign s_rdata   = rd_owner_loc ? '0 : m_rdata;
   assign m_rready  = s_rready && !rd_owner_loc;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_owner_loc <= 1'b0;
         loc_wr_ready <= 1'b0;
         loc_bvalid   <= 1'b0;
      end else begin
         loc_wr_ready <= loc_wr_start;
         loc_bvalid   <= loc_wr_start || (loc_bvalid && !s_bready);
         // owner moves only once b is clear, so the old response routes home
         if (wr_req && wr_free) begin
            wr_owner_loc <= !aw_hit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_owner_loc <= 1'b0;
         loc_arready  <= 1'b0;
         loc_rvalid   <= 1'b0;
      end else begin
         loc_arready <= loc_rd_start;
         loc_rvalid  <= loc_rd_start || (loc_rvalid && !s_rready);
         if (s_arvalid && rd_free) begin
            rd_owner_loc <= !ar_hit;
         end
      end
   end

endmodule

//--- design/axil_mem_top.sv
`timescale 1ns/1ps

// scratch ram subsystem top level
// external axi4-lite slave port through the decoder into the ram
// debug port wired straight to the ram

module axil_mem_top #(
   parameter int DATA_WIDTH = axil_mem_pkg::AXIL_DATA_WIDTH,
   parameter int RAM_ADDR_WIDTH = axil_mem_pkg::RAM_ADDR_WIDTH,
   localparam int STRB_WIDTH = DATA_WIDTH / 8,
   localparam int WORD_ADDR_WIDTH = RAM_ADDR_WIDTH - $clog2(STRB_WIDTH)
) (
   input  logic                                     clk,
   input  logic                                     rst,

   // external axi4-lite slave port
   input  logic [axil_mem_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
   input  logic                                     awvalid,
   output logic                                     awready,
   input  logic [DATA_WIDTH-1:0]                    wdata,
   input  logic [STRB_WIDTH-1:0]                    wstrb,
   input  logic                                     wvalid,
   output logic                                     wready,
   output axil_mem_pkg::resp_t                      bresp,
   output logic                                     bvalid,
   input  logic                                     bready,
   input  logic [axil_mem_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                                     arvalid,
   output logic                                     arready,
   output logic [DATA_WIDTH-1:0]                    rdata,
   output axil_mem_pkg::resp_t                      rresp,
   output logic                                     rvalid,
   input  logic                                     rready,

   // debug port, word indexed
   input  logic [WORD_ADDR_WIDTH-1:0]               debug_addr,
   output logic [DATA_WIDTH-1:0]                    debug_data,
   input  logic [WORD_ADDR_WIDTH-1:0]               debug_wr_addr,
   input  logic [DATA_WIDTH-1:0]                    debug_wr_data,
   input  logic                                     debug_wr_en
);
   import axil_mem_pkg::*;

   // decoder to ram
   logic [RAM_ADDR_WIDTH-1:0] ram_awaddr;
   logic                      ram_awvalid;
   logic                      ram_awready;
   logic [DATA_WIDTH-1:0]     ram_wdata;
   logic [STRB_WIDTH-1:0]     ram_wstrb;
   logic                      ram_wvalid;
   logic                      ram_wready;
   resp_t                     ram_bresp;
   logic                      ram_bvalid;
   logic                      ram_bready;
   logic [RAM_ADDR_WIDTH-1:0] ram_araddr;
   logic                      ram_arvalid;
   logic                      ram_arready;
   logic [DATA_WIDTH-1:0]     ram_rdata;
   resp_t                     ram_rresp;
   logic                      ram_rvalid;
   logic                      ram_rready;

   axil_addr_decoder #(
      .ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) i_axil_addr_decoder (
      .clk       (clk),
      .rst       (rst),
      .s_awaddr  (awaddr),
      .s_awvalid (awvalid),
      .s_awready (awready),
      .s_wdata   (wdata),
      .s_wstrb   (wstrb),
      .s_wvalid  (wvalid),
      .s_wready  (wready),
      .s_bresp   (bresp),
      .s_bvalid  (bvalid),
      .s_bready  (bready),
      .s_araddr  (araddr),
      .s_arvalid (arvalid),
      .s_arready (arready),
      .s_rdata   (rdata),
      .s_rresp   (rresp),
      .s_rvalid  (rvalid),
      .s_rready  (rready),
      .m_awaddr  (ram_awaddr),
      .m_awvalid (ram_awvalid),
      .m_awready (ram_awready),
      .m_wdata   (ram_wdata),
      .m_wstrb   (ram_wstrb),
      .m_wvalid  (ram_wvalid),
      .m_wready  (ram_wready),
      .m_bresp   (ram_bresp),
      .m_bvalid  (ram_bvalid),
      .m_bready  (ram_bready),
      .m_araddr  (ram_araddr),
      .m_arvalid (ram_arvalid),
      .m_arready (ram_arready),
      .m_rdata   (ram_rdata),
      .m_rresp   (ram_rresp),
      .m_rvalid  (ram_rvalid),
      .m_rready  (ram_rready)
   );

   axil_ram #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) i_axil_ram (
      .clk           (clk),
      .rst           (rst),
      .debug_addr    (debug_addr),
      .debug_data    (debug_data),
      .debug_wr_addr (debug_wr_addr),
      .debug_wr_data (debug_wr_data),
      .debug_wr_en   (debug_wr_en),
      .awaddr        (ram_awaddr),
      .awvalid       (ram_awvalid),
      .awready       (ram_awready),
      .wdata         (ram_wdata),
      .wstrb         (ram_wstrb),
      .wvalid        (ram_wvalid),
      .wready        (ram_wready),
      .bresp         (ram_bresp),
      .bvalid        (ram_bvalid),
      .bready        (ram_bready),
      .araddr        (ram_araddr),
      .arvalid       (ram_arvalid),
      .arready       (ram_arready),
      .rdata         (ram_rdata),
      .rresp         (ram_rresp),
      .rvalid        (ram_rvalid),
      .rready        (ram_rready)
   );

endmodule

//--- bench/axil_mem_assertions.sv
`timescale 1ns/1ps

// handshake checks on the scratch ram subsystem top level
// a raised valid holds until its ready, responses clear out of reset

module axil_mem_assertions (
   input logic clk,
   input logic rst,
   input logic awvalid,
   input logic awready,
   input logic wvalid,
   input logic wready,
   input logic bvalid,
   input logic bready,
   input logic arvalid,
   input logic arready,
   input logic rvalid,
   input logic rready
);

   // master side, request valids
   aw_valid_held: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid)
      else $error("awvalid dropped before awready");

   w_valid_held: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid)
      else $error("wvalid dropped before wready");

   ar_valid_held: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid)
      else $error("arvalid dropped before arready");

   // slave side, responses wait on the master
   b_valid_held: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   r_valid_held: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // no stale response out of reset
   resp_low_after_reset: assert property (@(posedge clk)
      rst |=> !bvalid && !rvalid)
      else $error("response valid high in the cycle after reset");

endmodule

bind axil_mem_top axil_mem_assertions i_axil_mem_assertions (
   .clk     (clk),
   .rst     (rst),
   .awvalid (awvalid),
   .awready (awready),
   .wvalid  (wvalid),
   .wready  (wready),
   .bvalid  (bvalid),
   .bready  (bready),
   .arvalid (arvalid),
   .arready (arready),
   .rvalid  (rvalid),
   .rready  (rready)
);

//--- bench/tb_axil_mem.sv
`timescale 1ns/1ps

// directed testbench for the scratch ram subsystem
// drives the axi4-lite and debug ports and checks against a word model

module tb_axil_mem;
   import axil_mem_pkg::*;

   localparam int DATA_WIDTH = AXIL_DATA_WIDTH;
   localparam int STRB_WIDTH = AXIL_STRB_WIDTH;
   localparam int WORD_SHIFT = $clog2(STRB_WIDTH);
   localparam int WORD_ADDR_WIDTH = RAM_ADDR_WIDTH - WORD_SHIFT;
   localparam int WORDS = 2 ** WORD_ADDR_WIDTH;
   localparam int RESET_CYCLES = 10;
   // bus and debug transactions summed over tests 1 to 5
   localparam int TEST_TXNS = 32 + 7 + 16 + 4 + 4;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_TXNS * 20;

   logic                       clk = 1'b0;
   logic                       rst;
   logic [AXIL_ADDR_WIDTH-1:0] awaddr;
   logic                       awvalid;
   logic                       awready;
   logic [DATA_WIDTH-1:0]      wdata;
   logic [STRB_WIDTH-1:0]      wstrb;
   logic                       wvalid;
   logic                       wready;
   resp_t                      bresp;
   logic                       bvalid;
   logic                       bready;
   logic [AXIL_ADDR_WIDTH-1:0] araddr;
   logic                       arvalid;
   logic                       arready;
   logic [DATA_WIDTH-1:0]      rdata;
   resp_t                      rresp;
   logic                       rvalid;
   logic                       rready;
   logic [WORD_ADDR_WIDTH-1:0] debug_addr;
   logic [DATA_WIDTH-1:0]      debug_data;
   logic [WORD_ADDR_WIDTH-1:0] debug_wr_addr;
   logic [DATA_WIDTH-1:0]      debug_wr_data;
   logic                       debug_wr_en;

   // expected ram contents by word index
   logic [DATA_WIDTH-1:0]      model [WORDS];
   logic [31:0]                lcg_state = 32'd2041;
   int                         check_count = 0;
   int                         error_count = 0;
   int                         errors_seen = 0;

   axil_mem_top #(
      .DATA_WIDTH     (DATA_WIDTH),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) i_axil_mem_top (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [AXIL_ADDR_WIDTH-1:0] byte_addr(
      input logic [WORD_ADDR_WIDTH-1:0] widx);
      return AXIL_ADDR_WIDTH'(widx) << WORD_SHIFT;
   endfunction

   // strobed bytes replace the old ones and the rest stay
   function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
      logic [DATA_WIDTH-1:0] res;
      res = old;
      for (int i = 0; i < STRB_WIDTH; i++) begin
         if (strb[i])
            res[8*i +: 8] = data[8*i +: 8];
      end
      return res;
   endfunction

   task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
      input logic [DATA_WIDTH-1:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic flag_error(input string msg);
      error_count++;
      $display("%s", msg);
   endtask

   task automatic report_test(input string name);
      if (error_count == errors_seen)
         $display("test %s: passed", name);
      else
         $display("test %s: %0d errors", name, error_count - errors_seen);
      errors_seen = error_count;
   endtask

   task automatic present_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
   endtask

   // address and data handshake on the edge that sees ready
   task automatic accept_write();
      do begin
         @(posedge clk);
      end while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   // bready held low for stall cycles while the response must not move
   task automatic take_write_resp(input int stall, output resp_t resp);
      resp_t first;
      while (!bvalid)
         @(posedge clk);
      first = bresp;
      repeat (stall) begin
         @(posedge clk);
         if (!bvalid)
            flag_error("bvalid dropped while bready was low");
         if (awready || wready)
            flag_error("write request accepted while a write response was pending");
         check_resp("bresp", bresp, first);
      end
      bready <= 1'b1;
      @(posedge clk);
      if (!bvalid)
         flag_error("bvalid gone at the bready edge");
      resp = bresp;
      bready <= 1'b0;
   endtask

   task automatic present_read(input logic [AXIL_ADDR_WIDTH-1:0] addr);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
   endtask

   task automatic accept_read();
      do begin
         @(posedge clk);
      end while (!arready);
      arvalid <= 1'b0;
   endtask

   task automatic take_read_resp(input int stall, output logic [DATA_WIDTH-1:0] data,
      output resp_t resp);
      logic [DATA_WIDTH-1:0] first;
      while (!rvalid)
         @(posedge clk);
      first = rdata;
      repeat (stall) begin
         @(posedge clk);
         if (!rvalid)
            flag_error("rvalid dropped while rready was low");
         if (arready)
            flag_error("read request accepted while read data was pending");
         check_data("rdata", rdata, first);
      end
      rready <= 1'b1;
      @(posedge clk);
      if (!rvalid)
         flag_error("rvalid gone at the rready edge");
      data = rdata;
      resp = rresp;
      rready <= 1'b0;
   endtask

   task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb,
      output resp_t resp);
      present_write(addr, data, strb);
      accept_write();
      take_write_resp(0, resp);
   endtask

   task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
      output logic [DATA_WIDTH-1:0] data, output resp_t resp);
      present_read(addr);
      accept_read();
      take_read_resp(0, data, resp);
   endtask

   // in-window write with the model following the strobes
   task automatic write_word(input logic [WORD_ADDR_WIDTH-1:0] widx,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
      resp_t resp;
      axil_write(byte_addr(widx), data, strb, resp);
      check_resp("bresp", resp, RESP_OKAY);
      model[widx] = merge_bytes(model[widx], data, strb);
   endtask

   task automatic read_check(input logic [WORD_ADDR_WIDTH-1:0] widx);
      logic [DATA_WIDTH-1:0] data;
      resp_t                 resp;
      axil_read(byte_addr(widx), data, resp);
      check_resp("rresp", resp, RESP_OKAY);
      check_data("rdata", data, model[widx]);
   endtask

   task automatic debug_write(input logic [WORD_ADDR_WIDTH-1:0] widx,
      input logic [DATA_WIDTH-1:0] data);
      @(posedge clk);
      debug_wr_addr <= widx;
      debug_wr_data <= data;
      debug_wr_en   <= 1'b1;
      @(posedge clk);
      debug_wr_en   <= 1'b0;
      model[widx] = data;
   endtask

   // combinational read settles by the next edge
   task automatic debug_read(input logic [WORD_ADDR_WIDTH-1:0] widx,
      output logic [DATA_WIDTH-1:0] data);
      @(posedge clk);
      debug_addr <= widx;
      @(posedge clk);
      data = debug_data;
   endtask

   task automatic full_word_write_read();
      logic [WORD_ADDR_WIDTH-1:0] words [16];
      logic [31:0]                rnd;
      for (int i = 0; i < 16; i++) begin
         rnd = lcg_next();
         words[i] = rnd[31 -: WORD_ADDR_WIDTH];
         write_word(words[i], lcg_next(), '1);
      end
      for (int i = 0; i < 16; i++)
         read_check(words[i]);
   endtask

   task automatic partial_strobe_writes();
      localparam logic [WORD_ADDR_WIDTH-1:0] WIDX = 100;
      write_word(WIDX, lcg_next(), '1);
      write_word(WIDX, lcg_next(), 4'b0001);
      read_check(WIDX);
      write_word(WIDX, lcg_next(), 4'b0110);
      read_check(WIDX);
      write_word(WIDX, lcg_next(), 4'b1000);
      read_check(WIDX);
   endtask

   task automatic debug_port_crosscheck();
      logic [DATA_WIDTH-1:0] data;
      // preload by debug and read over the bus
      for (int i = 0; i < 4; i++)
         debug_write(WORD_ADDR_WIDTH'(200 + i), lcg_next());
      for (int i = 0; i < 4; i++)
         read_check(WORD_ADDR_WIDTH'(200 + i));
      // and the other way round
      for (int i = 0; i < 4; i++)
         write_word(WORD_ADDR_WIDTH'(300 + i), lcg_next(), '1);
      for (int i = 0; i < 4; i++) begin
         debug_read(WORD_ADDR_WIDTH'(300 + i), data);
         check_data("debug_data", data, model[300 + i]);
      end
   endtask

   task automatic out_of_window_access();
      localparam logic [WORD_ADDR_WIDTH-1:0] WIDX = 5;
      logic [DATA_WIDTH-1:0] data;
      resp_t                 resp;
      debug_write(WIDX, lcg_next());
      // bit 12 set would alias onto WIDX if truncated
      axil_write(byte_addr(WIDX) | 16'h1000, lcg_next(), '1, resp);
      check_resp("bresp", resp, RESP_DECERR);
      axil_read(byte_addr(WIDX) | 16'h8000, data, resp);
      check_resp("rresp", resp, RESP_DECERR);
      check_data("rdata", data, '0);
      read_check(WIDX);
   endtask

   task automatic stalled_responses();
      localparam logic [WORD_ADDR_WIDTH-1:0] WA = 400;
      localparam logic [WORD_ADDR_WIDTH-1:0] WB = 401;
      logic [DATA_WIDTH-1:0] data_a;
      logic [DATA_WIDTH-1:0] data_b;
      logic [DATA_WIDTH-1:0] data;
      resp_t                 resp;
      data_a = lcg_next();
      data_b = lcg_next();
      // second write waits behind the stalled response
      present_write(byte_addr(WA), data_a, '1);
      accept_write();
      present_write(byte_addr(WB), data_b, '1);
      take_write_resp(6, resp);
      check_resp("bresp", resp, RESP_OKAY);
      accept_write();
      take_write_resp(0, resp);
      check_resp("bresp", resp, RESP_OKAY);
      model[WA] = data_a;
      model[WB] = data_b;
      // same for reads
      present_read(byte_addr(WA));
      accept_read();
      present_read(byte_addr(WB));
      take_read_resp(6, data, resp);
      check_resp("rresp", resp, RESP_OKAY);
      check_data("rdata", data, model[WA]);
      accept_read();
      take_read_resp(0, data, resp);
      check_resp("rresp", resp, RESP_OKAY);
      check_data("rdata", data, model[WB]);
   endtask

   // hard stop if a handshake never comes
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      rst           = 1'b1;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wstrb         = '0;
      wvalid        = 1'b0;
      bready        = 1'b0;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b0;
      debug_addr    = '0;
      debug_wr_addr = '0;
      debug_wr_data = '0;
      debug_wr_en   = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      full_word_write_read();
      report_test("1 full word write and read");
      partial_strobe_writes();
      report_test("2 byte strobes");
      debug_port_crosscheck();
      report_test("3 debug port");
      out_of_window_access();
      report_test("4 decode error");
      stalled_responses();
      report_test("5 back-pressure");

      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- sim.f
design/axil_mem_pkg.sv
design/axil_ram.sv
design/axil_addr_decoder.sv
design/axil_mem_top.sv
bench/axil_mem_assertions.sv
bench/tb_axil_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the scratch ram testbench with verilator and runs it
# exits nonzero when the build or the run fails, or the log shows errors

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_axil_mem --Mdir obj_dir -o tb_axil_mem \
   -f sim.f > build.log 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/tb_axil_mem > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   echo "simulation reported errors"
   exit 1
fi

echo "simulation passed"
exit 0
